//--- Bender.yml
package:
  name: control_unit

sources:
  - verilog/decodePkg.sv
  - verilog/instrClassifier.sv
  - verilog/aluDecoder.sv
  - verilog/memStackDecoder.sv
  - verilog/branchDecoder.sv
  - verilog/controlUnit.sv
  - target: simulation
    files:
      - verification/controlUnitTb.sv

//--- sim.f
verilog/decodePkg.sv
verilog/instrClassifier.sv
verilog/aluDecoder.sv
verilog/memStackDecoder.sv
verilog/branchDecoder.sv
verilog/controlUnit.sv
verification/controlUnitTb.sv

//--- verification/controlUnitTb.sv
`timescale 1ns/10ps

module controlUnitTb;
	import decodePkg::*;

	localparam int waitLimit = 8;

	logic clk;
	logic rst;
	instrIn_t instrIn;
	flags_t flags;
	ctrlOut_t ctrlOut;

	// Copies of the previous edge, for one-cycle-late comparisons
	instrIn_t prevIn;
	flags_t prevFlags;
	ctrlWord_t prevCtrl;
	logic prevRst = 1'b0;
	ctrlWord_t onlyPcIncr;

	logic [instrWidth-1:0] pw;
	logic destPair;
	logic isRegArith;
	logic isImm;
	logic isJump;
	logic isPush;
	logic isPairPop;
	logic isNop;
	logic expTake;
	logic [14:0] gotArith;
	logic [14:0] expArith;
	logic [17:0] gotJump;
	logic [17:0] expJump;
	logic [5:0] gotPush;
	logic [2:0] gotPop;

	int errors;
	int testStartErrors;
	int testsRun;
	int testsFailed;
	logic timedOut;
	logic [31:0] lcgState;

	controlUnit controlUnit_i (
		.clk(clk),
		.rst(rst),
		.instrIn(instrIn),
		.flags(flags),
		.ctrlOut(ctrlOut)
	);

	initial begin
		clk = 1'b0;
	end

	always #20 clk = ~clk;

	always @(posedge clk) begin
		prevIn <= instrIn;
		prevFlags <= flags;
		prevCtrl <= ctrlOut.ctrl;
		prevRst <= rst;
	end

	////////////////////////////////////////////////////////////
	// Expected control from the previous word
	////////////////////////////////////////////////////////////

	assign pw = prevIn.word;
	assign destPair = (pw[11:8] == 4'd12) || (pw[11:8] == 4'd13);
	assign isRegArith = (pw[17:12] == 6'b000000) && (pw[7:4] >= 4'h2) && (pw[7:4] <= 4'hA);
	assign isImm = (pw[17:16] == 2'b00) && (pw[15:12] >= 4'h2) && (pw[15:12] <= 4'hD);
	assign isJump = (pw[17:16] == 2'b10) && (pw[15:13] != 3'b111);
	assign isPush = (pw[17:16] == 2'b11) && ((pw[15:14] == 2'b01) || (pw[15:14] == 2'b10));
	assign isPairPop = (pw[17:14] == 4'b1100) && ((pw[13:10] == 4'd12) || (pw[13:10] == 4'd13));
	// MUL/FMUL in both forms, plus the unused codes at the top of two groups
	assign isNop = ((pw[17:12] == 6'b000000) && (pw[7:4] >= 4'hE))
		|| ((pw[17:16] == 2'b00) && (pw[15:12] >= 4'hE))
		|| (pw[17:13] == 5'b11111) || (pw[17:13] == 5'b10111);

	always_comb begin
		case (pw[15:13])
			3'd0: expTake = 1'b1;
			3'd1: expTake = prevFlags.zero;
			3'd2: expTake = !prevFlags.zero;
			3'd3: expTake = prevFlags.negative;
			3'd4: expTake = prevFlags.negative || prevFlags.zero;
			3'd5: expTake = prevFlags.low;
			3'd6: expTake = prevFlags.low || prevFlags.zero;
			default: expTake = 1'b0;
		endcase
	end

	assign gotArith = {ctrlOut.ctrl.aluOp, ctrlOut.ctrl.srcSel, ctrlOut.ctrl.destSel,
		ctrlOut.ctrl.flagWrite, ctrlOut.ctrl.writeEn1, ctrlOut.ctrl.writeEn2};
	assign expArith = {pw[7:4], pw[3:0], pw[11:8], 1'b1, !destPair, destPair};
	assign gotJump = {ctrlOut.ctrl.bufCtrl.addrToPc, ctrlOut.ctrl.bufCtrl.pcIncr,
		ctrlOut.ctrl.addr};
	assign expJump = {expTake, !expTake, 2'b00, pw[13:0]};
	assign gotPush = {ctrlOut.ctrl.memWrite, ctrlOut.ctrl.writeEn2, ctrlOut.ctrl.destSel2};
	assign gotPop = {ctrlOut.ctrl.writeEn1, ctrlOut.ctrl.writeEn2, ctrlOut.ctrl.memRead};

	////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////

	resetClear: assert property (@(posedge clk) prevRst |-> ctrlOut == '0)
		else begin
			errors++;
			$display("mismatch at %0t: ctrlOut got %h expected 0", $time, $sampled(ctrlOut));
		end

	validFollows: assert property (@(posedge clk) disable iff (rst)
		ctrlOut.valid == prevIn.valid)
		else begin
			errors++;
			$display("mismatch at %0t: ctrlOut.valid got %b expected %b", $time,
				$sampled(ctrlOut.valid), $sampled(prevIn.valid));
		end

	holdWord: assert property (@(posedge clk) disable iff (rst)
		!prevRst && !prevIn.valid |-> ctrlOut.ctrl == prevCtrl)
		else begin
			errors++;
			$display("mismatch at %0t: ctrlOut.ctrl got %h expected %h", $time,
				$sampled(ctrlOut.ctrl), $sampled(prevCtrl));
		end

	regArith: assert property (@(posedge clk) disable iff (rst)
		prevIn.valid && isRegArith |-> gotArith == expArith)
		else begin
			errors++;
			$display("mismatch at %0t: %s got %h expected %h", $time,
				"{aluOp,srcSel,destSel,flagWrite,writeEn1,writeEn2}",
				$sampled(gotArith), $sampled(expArith));
		end

	jumpCond: assert property (@(posedge clk) disable iff (rst)
		prevIn.valid && isJump |-> gotJump == expJump)
		else begin
			errors++;
			$display("mismatch at %0t: {addrToPc,pcIncr,addr} got %h expected %h", $time,
				$sampled(gotJump), $sampled(expJump));
		end

	pushWrite: assert property (@(posedge clk) disable iff (rst)
		prevIn.valid && isPush |-> gotPush == {2'b11, stackPtr})
		else begin
			errors++;
			$display("mismatch at %0t: {memWrite,writeEn2,destSel2} got %h expected %h", $time,
				$sampled(gotPush), {2'b11, stackPtr});
		end

	pairPop: assert property (@(posedge clk) disable iff (rst)
		prevIn.valid && isPairPop |-> gotPop == 3'b000)
		else begin
			errors++;
			$display("mismatch at %0t: {writeEn1,writeEn2,memRead} got %b expected 000", $time,
				$sampled(gotPop));
		end

	immField: assert property (@(posedge clk) disable iff (rst)
		prevIn.valid && isImm |-> ctrlOut.ctrl.immediate == {8'h00, pw[7:0]})
		else begin
			errors++;
			$display("mismatch at %0t: immediate got %h expected %h", $time,
				$sampled(ctrlOut.ctrl.immediate), {8'h00, $sampled(pw[7:0])});
		end

	nopOnly: assert property (@(posedge clk) disable iff (rst)
		prevIn.valid && isNop |-> ctrlOut.ctrl == onlyPcIncr)
		else begin
			errors++;
			$display("mismatch at %0t: ctrlOut.ctrl got %h expected %h", $time,
				$sampled(ctrlOut.ctrl), onlyPcIncr);
		end

	memExcl: assert property (@(posedge clk) disable iff (rst)
		ctrlOut.valid |-> !(ctrlOut.ctrl.memRead && ctrlOut.ctrl.memWrite))
		else begin
			errors++;
			$display("memRead and memWrite are both set at %0t", $time);
		end

	pcExcl: assert property (@(posedge clk) disable iff (rst)
		ctrlOut.valid |-> !(ctrlOut.ctrl.bufCtrl.addrToPc && ctrlOut.ctrl.bufCtrl.pcIncr))
		else begin
			errors++;
			$display("addrToPc and pcIncr are both set at %0t", $time);
		end

	////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////

	function automatic logic [31:0] nextRandom(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// Called on a falling edge, returns on the falling edge after valid out
	task automatic sendWord(input logic [instrWidth-1:0] word, input flags_t f);
		int waited;
		if (!timedOut) begin
			instrIn.valid = 1'b1;
			instrIn.word = word;
			flags = f;
			waited = 0;
			do begin
				@(negedge clk);
				waited++;
			end while (!ctrlOut.valid && waited < waitLimit);
			if (!ctrlOut.valid) begin
				timedOut = 1'b1;
				errors++;
				$display("timeout: no valid output within %0d cycles at %0t", waitLimit, $time);
			end
		end
	endtask

	task automatic idleCycles(input int n);
		instrIn.valid = 1'b0;
		repeat (n) @(negedge clk);
	endtask

	task automatic finishTest(input string name);
		int found;
		idleCycles(2);
		found = errors - testStartErrors;
		testsRun++;
		if (found != 0) begin
			testsFailed++;
		end
		$display("%s: %0d errors", name, found);
		testStartErrors = errors;
	endtask

	initial begin
		int i;
		int j;
		flags_t f;
		rst = 1'b1;
		instrIn = '0;
		flags = '0;
		errors = 0;
		testStartErrors = 0;
		testsRun = 0;
		testsFailed = 0;
		timedOut = 1'b0;
		onlyPcIncr = '0;
		onlyPcIncr.bufCtrl.pcIncr = 1'b1;
		lcgState = 32'd41548;

		repeat (10) @(negedge clk);
		rst = 1'b0;
		finishTest("reset");

		// Dest runs 5..15 then wraps, so 12 and 13 get hit
		for (i = 2; i <= 15; i++) begin
			sendWord({6'b000000, 4'(i + 3), 4'(i), 4'(15 - i)}, '0);
		end
		finishTest("register ALU");

		for (i = 2; i <= 15; i++) begin
			sendWord({2'b00, 4'(i), 4'(i), 8'(8'hA5 ^ i)}, '0);
		end
		finishTest("immediate ALU");

		for (i = 0; i < 16; i++) begin
			sendWord({6'b000001, 4'(i), 4'h0, 4'(15 - i)}, '0);
			sendWord({6'b000001, 4'(i), 4'h1, 4'(i)}, '0);
			sendWord({4'b1100, 4'(i), 10'h000}, '0);
			sendWord({4'b1101, 4'(i), 10'h003}, '0);
			sendWord({6'b111100, 4'(i), 8'h00}, '0);
			sendWord({6'b111101, 4'(i), 8'h00}, '0);
		end
		sendWord({4'b1110, 14'h2ABC}, '0);
		finishTest("memory and stack");

		// CALL, MOVMRI, MOVRMI, RET, then every jump under every flag mix
		for (i = 0; i < 4; i++) begin
			sendWord({2'b01, 2'(i), 14'(14'h00F0 + i)}, '0);
		end
		for (i = 0; i < 7; i++) begin
			for (j = 0; j < 8; j++) begin
				sendWord({2'b10, 3'(i), 13'(13'h1234 + j)}, flags_t'(3'(j)));
			end
		end
		finishTest("special group");

		sendWord({6'b000000, 4'h3, 4'hE, 4'h1}, '0);
		sendWord({6'b000000, 4'h3, 4'hF, 4'h1}, '0);
		sendWord({2'b00, 4'hE, 12'h345}, '0);
		sendWord({2'b00, 4'hF, 12'h345}, '0);
		sendWord({5'b11111, 13'h0AAA}, '0);
		sendWord({5'b11111, 13'h1555}, '0);
		sendWord({5'b10111, 13'h0F0F}, '0);
		finishTest("no-op encodings");

		for (i = 0; i < 400; i++) begin
			lcgState = nextRandom(lcgState);
			f = flags_t'(lcgState[30:28]);
			lcgState = nextRandom(lcgState);
			sendWord(lcgState[31:14], f);
			if (lcgState[13:11] == 3'd0) begin
				idleCycles(1);
			end
		end
		finishTest("random traffic");

		$display("tests run: %0d, failed: %0d, errors: %0d", testsRun, testsFailed, errors);
		if (errors == 0 && !timedOut) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

//--- verilog/aluDecoder.sv
`timescale 1ns/10ps

module aluDecoder (
	input logic [decodePkg::instrWidth-1:0] instr,
	output decodePkg::ctrlWord_t ctrl
);
	import decodePkg::*;

	logic immForm;
	logic pair;
	aluOp_t op;
	logic [selWidth-1:0] dest;

	// Non-zero group means immediate form, opcode in the group
	assign immForm = (instr[15:12] != 4'd0);
	assign op = immForm ? aluOp_t'(instr[15:12]) : aluOp_t'(instr[7:4]);
	assign dest = instr[11:8];
	assign pair = isPairReg(dest);

	always_comb begin
		ctrl = nopWord();

		// Operand routing shared by every handled op
		ctrl.aluOp = op;
		ctrl.destSel = dest;
		ctrl.destSel2 = dest;
		ctrl.srcSel = immForm ? dest : instr[3:0];
		ctrl.immediate = immForm ? {{(dataWidth-8){1'b0}}, instr[7:0]} : '0;
		ctrl.bufCtrl.immToBus = immForm;
		ctrl.bufCtrl.regToBus = !immForm;

		case (op)
			ADD, SUB, AND, OR, XOR, NOT, LSH, RSH, ARSH: begin
				ctrl.flagWrite = 1'b1;
				ctrl.writeEn1 = !pair;
				ctrl.writeEn2 = pair;
				ctrl.bufCtrl.aluToRf1 = !pair;
				ctrl.bufCtrl.aluToRf2 = pair;
			end
			CMP, CMPR: begin
				// Flags only, no write back
				ctrl.flagWrite = 1'b1;
			end
			MOVR: begin
				ctrl.writeEn1 = !pair;
				ctrl.writeEn2 = pair;
				if (immForm) begin
					ctrl.bufCtrl.immMovToRf1 = !pair;
					ctrl.bufCtrl.immMovToRf2 = pair;
				end else begin
					ctrl.bufCtrl.movToRf1 = !pair;
					ctrl.bufCtrl.movToRf2 = pair;
				end
			end
			default: begin
				// MUL, FMUL and anything else
				ctrl = nopWord();
			end
		endcase
	end

endmodule

//--- verilog/branchDecoder.sv
`timescale 1ns/10ps

module branchDecoder (
	input logic [decodePkg::instrWidth-1:0] instr,
	input decodePkg::flags_t flags,
	output decodePkg::ctrlWord_t ctrl
);
	import decodePkg::*;

	specialOp_t op;
	logic take;

	// Prefix 01 holds the 4-bit ops, prefix 10 the 5-bit jumps
	assign op = (instr[17:16] == 2'b01) ? specialOp_t'({instr[17:14], 1'b0})
		: specialOp_t'(instr[17:13]);

	// Jump condition
	always_comb begin
		case (op)
			J: take = 1'b1;
			JE: take = flags.zero;
			JNE: take = !flags.zero;
			JL: take = flags.negative;
			JLE: take = flags.negative || flags.zero;
			JB: take = flags.low;
			JBE: take = flags.low || flags.zero;
			default: take = 1'b0;
		endcase
	end

	always_comb begin
		ctrl = nopWord();
		ctrl.addr = {{(dataWidth-14){1'b0}}, instr[13:0]};
		ctrl.destSel = pcReg;

		case (op)
			CALL: begin
				// Push the PC, bump SP, load the target
				ctrl.srcSel = stackPtr;
				ctrl.destSel2 = stackPtr;
				ctrl.memWrite = 1'b1;
				ctrl.writeEn2 = 1'b1;
				ctrl.bufCtrl.regToAddr = 1'b1;
				ctrl.bufCtrl.pcToMem = 1'b1;
				ctrl.bufCtrl.incDecToRf2 = 1'b1;
				ctrl.bufCtrl.increment = 1'b1;
				ctrl.bufCtrl.addrToPc = 1'b1;
				ctrl.bufCtrl.pcIncr = 1'b0;
			end
			RET: begin
				// pcIncr stays so the slot after RET still runs
				ctrl.srcSel = stackPtr;
				ctrl.destSel2 = stackPtr;
				ctrl.memRead = 1'b1;
				ctrl.ret = 1'b1;
				ctrl.bufCtrl.regToAddr = 1'b1;
				ctrl.bufCtrl.memToPc = 1'b1;
				ctrl.bufCtrl.retToPc = 1'b1;
			end
			MOVMRI: begin
				ctrl.destSel = '0;
				ctrl.memRead = 1'b1;
				ctrl.writeEn1 = 1'b1;
				ctrl.bufCtrl.immToAddr = 1'b1;
				ctrl.bufCtrl.memToRf1 = 1'b1;
			end
			MOVRMI: begin
				ctrl.srcSel = '0;
				ctrl.memWrite = 1'b1;
				ctrl.bufCtrl.regToBus = 1'b1;
				ctrl.bufCtrl.immToAddr = 1'b1;
				ctrl.bufCtrl.dataToMem = 1'b1;
			end
			J, JE, JNE, JL, JLE, JB, JBE: begin
				ctrl.bufCtrl.immToAddr = 1'b1;
				ctrl.bufCtrl.addrToPc = take;
				ctrl.bufCtrl.pcIncr = !take;
			end
			default: begin
				ctrl = nopWord();
			end
		endcase
	end

endmodule

//--- verilog/controlUnit.sv
`timescale 1ns/10ps

module controlUnit (
	input logic clk,
	input logic rst,
	input decodePkg::instrIn_t instrIn,
	input decodePkg::flags_t flags,
	output decodePkg::ctrlOut_t ctrlOut
);
	import decodePkg::*;

	instrClass_t instrClass;
	ctrlWord_t aluCtrl;
	ctrlWord_t memCtrl;
	ctrlWord_t branchCtrl;
	ctrlWord_t nextCtrl;

	instrClassifier instrClassifier_i (
		.instr(instrIn.word),
		.instrClass(instrClass)
	);

	aluDecoder aluDecoder_i (
		.instr(instrIn.word),
		.ctrl(aluCtrl)
	);

	memStackDecoder memStackDecoder_i (
		.instr(instrIn.word),
		.ctrl(memCtrl)
	);

	branchDecoder branchDecoder_i (
		.instr(instrIn.word),
		.flags(flags),
		.ctrl(branchCtrl)
	);

	always_comb begin
		case (instrClass)
			normReg, normImm: nextCtrl = aluCtrl;
			normMem, stackOp, incDec: nextCtrl = memCtrl;
			special14: nextCtrl = branchCtrl;
			default: nextCtrl = nopWord();
		endcase
	end

	// Word holds while the input is idle
	always_ff @(posedge clk) begin
		if (rst) begin
			ctrlOut <= '0;
		end else begin
			ctrlOut.valid <= instrIn.valid;
			if (instrIn.valid) begin
				ctrlOut.ctrl <= nextCtrl;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////

	memExclusive: assert property (@(posedge clk) disable iff (rst)
		ctrlOut.valid |-> !(ctrlOut.ctrl.memRead && ctrlOut.ctrl.memWrite))
		else $error("memRead and memWrite both set");

	pcExclusive: assert property (@(posedge clk) disable iff (rst)
		ctrlOut.valid |-> !(ctrlOut.ctrl.bufCtrl.addrToPc && ctrlOut.ctrl.bufCtrl.pcIncr))
		else $error("addrToPc and pcIncr both set");

	// One cycle of latency, never more
	validLatency: assert property (@(posedge clk) disable iff (rst)
		1'b1 |=> (ctrlOut.valid == $past(instrIn.valid)))
		else $error("valid out does not follow valid in");

endmodule

//--- verilog/decodePkg.sv
package decodePkg;

	localparam int instrWidth = 18;
	localparam int dataWidth = 16;
	localparam int selWidth = 4;

	// Register file indices
	localparam logic [selWidth-1:0] linkReg = 4'd12;
	localparam logic [selWidth-1:0] stackPtr = 4'd13;
	localparam logic [selWidth-1:0] pcReg = 4'd15;

	////////////////////////////////////////////////////////////
	// Opcodes
	////////////////////////////////////////////////////////////

	// Groups 0 and 1 are taken by the register forms, so the
	// immediate-capable ops start at 2
	typedef enum logic [3:0] {
		ADD = 4'h2,
		SUB = 4'h3,
		AND = 4'h4,
		OR = 4'h5,
		XOR = 4'h6,
		NOT = 4'h7,
		LSH = 4'h8,
		RSH = 4'h9,
		ARSH = 4'hA,
		CMP = 4'hB,
		CMPR = 4'hC,
		MOVR = 4'hD,
		MUL = 4'hE,
		FMUL = 4'hF,
		MOVMR = 4'h0,
		MOVRM = 4'h1
	} aluOp_t;

	// 4-bit codes padded with a zero LSB
	typedef enum logic [4:0] {
		CALL = 5'b01000,
		MOVMRI = 5'b01010,
		MOVRMI = 5'b01100,
		RET = 5'b01110,
		J = 5'b10000,
		JE = 5'b10001,
		JNE = 5'b10010,
		JL = 5'b10011,
		JLE = 5'b10100,
		JB = 5'b10101,
		JBE = 5'b10110
	} specialOp_t;

	// 4-bit codes padded with two zero LSBs
	typedef enum logic [5:0] {
		POP = 6'b110000,
		PUSH = 6'b110100,
		PUSHI = 6'b111000,
		INCR = 6'b111100,
		DECR = 6'b111101
	} stackOp_t;

	typedef enum logic [2:0] {
		normReg,
		normMem,
		normImm,
		special14,
		stackOp,
		incDec,
		illegal
	} instrClass_t;

	////////////////////////////////////////////////////////////
	// Control structs
	////////////////////////////////////////////////////////////

	typedef struct packed {
		logic low;
		logic negative;
		logic zero;
	} flags_t;

	typedef struct packed {
		logic valid;
		logic [instrWidth-1:0] word;
	} instrIn_t;

	// MSB first, so immToBus lands on bit 0
	typedef struct packed {
		logic retToPc;
		logic increment;
		logic decrement;
		logic incDecToRf2;
		logic incDecToRf1;
		logic pcIncr;
		logic addrToPc;
		logic memToPc;
		logic memToRf2;
		logic memToRf1;
		logic pcToMem;
		logic dataToMem;
		logic immToAddr;
		logic regToAddr;
		logic movToRf2;
		logic movToRf1;
		logic immMovToRf2;
		logic immMovToRf1;
		logic aluToRf2;
		logic aluToRf1;
		logic regToBus;
		logic immToBus;
	} bufCtrl_t;

	typedef struct packed {
		aluOp_t aluOp;
		logic writeEn1;
		logic writeEn2;
		logic [dataWidth-1:0] immediate;
		bufCtrl_t bufCtrl;
		logic [selWidth-1:0] destSel;
		logic [selWidth-1:0] destSel2;
		logic [selWidth-1:0] srcSel;
		logic flagWrite;
		logic memWrite;
		logic memRead;
		logic [dataWidth-1:0] addr;
		logic ret;
	} ctrlWord_t;

	typedef struct packed {
		logic valid;
		ctrlWord_t ctrl;
	} ctrlOut_t;

	// Registers 12 and 13 sit on write port 2
	function automatic logic isPairReg(input logic [selWidth-1:0] sel);
		return (sel == linkReg) || (sel == stackPtr);
	endfunction

	// Safe no-op, only the PC moves on
	function automatic ctrlWord_t nopWord();
		ctrlWord_t w;
		w = '0;
		w.bufCtrl.pcIncr = 1'b1;
		return w;
	endfunction

endpackage

//--- verilog/instrClassifier.sv
`timescale 1ns/10ps

module instrClassifier (
	input logic [decodePkg::instrWidth-1:0] instr,
	output decodePkg::instrClass_t instrClass
);
	import decodePkg::*;

	logic [1:0] prefix;
	logic [3:0] group;

	assign prefix = instr[17:16];
	assign group = instr[15:12];

	always_comb begin
		case (prefix)
			2'b00: begin
				// Normal group
				if (group == 4'd0) begin
					instrClass = normReg;
				end else if (group == 4'd1) begin
					instrClass = normMem;
				end else begin
					instrClass = normImm;
				end
			end
			2'b01, 2'b10: begin
				instrClass = special14;
			end
			default: begin
				// Upper group bits finish the 4-bit code
				if (group[3:2] != 2'b11) begin
					instrClass = stackOp;
				end else if (group[1] == 1'b0) begin
					// Only INCR and DECR in the top code
					instrClass = incDec;
				end else begin
					instrClass = illegal;
				end
			end
		endcase
	end

endmodule

//--- verilog/memStackDecoder.sv
`timescale 1ns/10ps

module memStackDecoder (
	input logic [decodePkg::instrWidth-1:0] instr,
	output decodePkg::ctrlWord_t ctrl
);
	import decodePkg::*;

	logic stackForm;
	aluOp_t memOp;
	stackOp_t stackCode;
	logic [selWidth-1:0] fieldReg;
	logic [selWidth-1:0] operand;
	logic fieldPair;

	assign stackForm = (instr[17:16] == 2'b11);
	assign memOp = aluOp_t'(instr[7:4]);
	// INCR/DECR carry a 6-bit code, the rest a 4-bit one
	assign stackCode = (instr[15:14] == 2'b11) ? stackOp_t'(instr[17:12])
		: stackOp_t'({instr[17:14], 2'b00});
	assign fieldReg = instr[11:8];
	assign operand = instr[13:10];
	assign fieldPair = isPairReg(fieldReg);

	always_comb begin
		ctrl = nopWord();
		if (!stackForm) begin
			////////////////////////////////////////////////////////////
			// Register memory moves
			////////////////////////////////////////////////////////////
			ctrl.aluOp = memOp;
			ctrl.destSel = fieldReg;
			ctrl.destSel2 = fieldReg;
			ctrl.srcSel = instr[3:0];
			ctrl.bufCtrl.regToBus = 1'b1;
			ctrl.bufCtrl.regToAddr = 1'b1;
			case (memOp)
				MOVMR: begin
					ctrl.memRead = 1'b1;
					ctrl.writeEn1 = !fieldPair;
					ctrl.writeEn2 = fieldPair;
					ctrl.bufCtrl.memToRf1 = !fieldPair;
					ctrl.bufCtrl.memToRf2 = fieldPair;
				end
				MOVRM: begin
					ctrl.memWrite = 1'b1;
					ctrl.bufCtrl.dataToMem = 1'b1;
				end
				default: begin
					ctrl = nopWord();
				end
			endcase
		end else begin
			////////////////////////////////////////////////////////////
			// Stack and increment group
			////////////////////////////////////////////////////////////
			case (stackCode)
				POP: begin
					// Popping into the link register or SP does nothing
					if (!isPairReg(operand)) begin
						ctrl.srcSel = stackPtr;
						ctrl.destSel = operand;
						ctrl.destSel2 = stackPtr;
						ctrl.memRead = 1'b1;
						ctrl.writeEn1 = 1'b1;
						ctrl.bufCtrl.regToAddr = 1'b1;
						ctrl.bufCtrl.memToRf1 = 1'b1;
					end
				end
				PUSH, PUSHI: begin
					ctrl.srcSel = stackPtr;
					ctrl.destSel2 = stackPtr;
					ctrl.memWrite = 1'b1;
					ctrl.writeEn2 = 1'b1;
					ctrl.bufCtrl.regToAddr = 1'b1;
					ctrl.bufCtrl.dataToMem = 1'b1;
					ctrl.bufCtrl.incDecToRf2 = 1'b1;
					ctrl.bufCtrl.increment = 1'b1;
					if (stackCode == PUSHI) begin
						ctrl.immediate = {{(dataWidth-14){1'b0}}, instr[13:0]};
						ctrl.bufCtrl.immToBus = 1'b1;
					end else begin
						ctrl.destSel = operand;
						ctrl.bufCtrl.regToBus = 1'b1;
					end
				end
				INCR, DECR: begin
					ctrl.srcSel = fieldReg;
					ctrl.destSel = fieldReg;
					ctrl.destSel2 = fieldReg;
					ctrl.writeEn1 = !fieldPair;
					ctrl.writeEn2 = fieldPair;
					ctrl.bufCtrl.incDecToRf1 = !fieldPair;
					ctrl.bufCtrl.incDecToRf2 = fieldPair;
					ctrl.bufCtrl.increment = (stackCode == INCR);
					ctrl.bufCtrl.decrement = (stackCode == DECR);
				end
				default: begin
					ctrl = nopWord();
				end
			endcase
		end
	end

endmodule
